// File: verif/rv_exec_cases.txt
// instr rd value ovf ill, all hex; value is ignored when ill is 1
800000b7 01 80000000 0 0  // lui x1, 0x80000
80000137 02 80000000 0 0  // lui x2, 0x80000
fff10113 02 7fffffff 1 0  // addi x2, x2, -1
ffb00193 03 fffffffb 0 0  // addi x3, x0, -5
00300213 04 00000003 0 0  // addi x4, x0, 3
123452b7 05 12345000 0 0  // lui x5, 0x12345
67828293 05 12345678 0 0  // addi x5, x5, 0x678
01f00313 06 0000001f 0 0  // addi x6, x0, 31
004103b3 07 80000002 1 0  // add x7, x2, x4
40408433 08 7ffffffd 1 0  // sub x8, x1, x4
403204b3 09 00000008 0 0  // sub x9, x4, x3
00418533 0a fffffffe 0 0  // add x10, x3, x4
0032c5b3 0b edcba983 0 0  // xor x11, x5, x3
0042e633 0c 1234567b 0 0  // or x12, x5, x4
0011f6b3 0d 80000000 0 0  // and x13, x3, x1
0041a733 0e 00000001 0 0  // slt x14, x3, x4
0041b7b3 0f 00000000 0 0  // sltu x15, x3, x4
00322833 10 00000000 0 0  // slt x16, x4, x3
003238b3 11 00000001 0 0  // sltu x17, x4, x3
0030a933 12 00000001 0 0  // slt x18, x1, x3
006219b3 13 80000000 0 0  // sll x19, x4, x6
0041da33 14 1fffffff 0 0  // srl x20, x3, x4
4041dab3 15 ffffffff 0 0  // sra x21, x3, x4
4060db33 16 ffffffff 0 0  // sra x22, x1, x6
01f0db93 17 00000001 0 0  // srli x23, x1, 31
4011dc13 18 fffffffd 0 0  // srai x24, x3, 1
00429c93 19 23456780 0 0  // slli x25, x5, 4
ffc1ad13 1a 00000001 0 0  // slti x26, x3, -4
fff23d93 1b 00000001 0 0  // sltiu x27, x4, -1
fff2ce13 1c edcba987 0 0  // xori x28, x5, -1
0f026e93 1d 000000f3 0 0  // ori x29, x4, 0xf0
0ff2ff13 1e 00000078 0 0  // andi x30, x5, 0xff
00110f93 1f 80000000 1 0  // addi x31, x2, 1
00138393 07 80000003 0 0  // addi x7, x7, 1
007383b3 07 00000006 1 0  // add x7, x7, x7
40438433 08 00000003 0 0  // sub x8, x7, x4
00520013 00 00000008 0 0  // addi x0, x4, 5
004004b3 09 00000003 0 0  // add x9, x0, x4
0012050b 0a 00000000 0 1  // unknown opcode, rd x10
024205b3 0b 00000000 0 1  // add with funct7 0x01, rd x11
40121613 0c 00000000 0 1  // slli with imm[11:5] 0x20, rd x12
000506b3 0d fffffffe 0 0  // add x13, x10, x0
00c5e733 0e fffffffb 0 0  // or x14, x11, x12
ffffffff 00 00000000 0 0  // end of cases

// File: vlog.f
hw/rv_exec_pkg.sv
hw/rv_regfile.sv
hw/rv_adder.sv
hw/rv_alu.sv
hw/rv_decode.sv
hw/rv_result.sv
hw/rv_exec_top.sv
verif/rv_exec_checker.sv
verif/rv_exec_tb.sv

// File: run_sim.sh
#!/bin/bash
# build the execute slice testbench with Verilator, run it and check the log
verilator --binary --timing -f vlog.f --top-module rv_exec_tb -Mdir obj_dir -o rv_exec_sim \
    && ./obj_dir/rv_exec_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "^SIMULATION PASSED$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// File: verif/rv_exec_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_tb;
    import rv_exec_pkg::*;

    localparam int max_cases   = 64;
    localparam int half_period = 50;

    logic                 clk;
    logic                 reset;
    logic                 instr_valid;
    logic [ilen-1:0]      instr;
    logic                 retire_valid;
    logic [reg_idx_w-1:0] retire_rd;
    logic [xlen-1:0]      retire_value;
    logic                 retire_overflow;
    logic                 retire_illegal;
    retire_t              expected;
    logic                 final_check;
    int                   mismatch_count;
    int                   extra_count;
    int                   pending;
    logic [31:0]          case_mem [max_cases*5];   // five words per case
    int                   case_total;
    logic                 cases_ready;
    logic [31:0]          lfsr_state;

    rv_exec_top #(
        .reg_count (32)
    ) i_rv_exec_top (
        .clk             (clk),
        .reset           (reset),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .retire_valid    (retire_valid),
        .retire_rd       (retire_rd),
        .retire_value    (retire_value),
        .retire_overflow (retire_overflow),
        .retire_illegal  (retire_illegal)
    );

    rv_exec_checker i_rv_exec_checker (
        .clk             (clk),
        .reset           (reset),
        .retire_valid    (retire_valid),
        .retire_rd       (retire_rd),
        .retire_value    (retire_value),
        .retire_overflow (retire_overflow),
        .retire_illegal  (retire_illegal),
        .expected        (expected),
        .final_check     (final_check),
        .mismatch_count  (mismatch_count),
        .extra_count     (extra_count),
        .pending         (pending)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bit(output int b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0] ? 1 : 0;
    endtask

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        wait (cases_ready);
        repeat (case_total * 6 + 50) @(posedge clk);
        $display("timeout: %0d retirements still outstanding, run stopped", pending);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int b0;
        int b1;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        expected    = '0;
        final_check = 1'b0;
        cases_ready = 1'b0;
        case_total  = 0;
        lfsr_state  = 32'hb980_c032;
        $readmemh("verif/rv_exec_cases.txt", case_mem);
        while (case_total < max_cases && case_mem[case_total*5] != 32'hffff_ffff) begin
            case_total++;   // all ones word ends the list
        end
        cases_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < case_total; i++) begin
            take_bit(b0);
            take_bit(b1);
            instr_valid       = 1'b1;
            instr             = case_mem[i*5];
            expected.valid    = 1'b1;
            expected.rd       = case_mem[i*5+1][reg_idx_w-1:0];
            expected.value    = case_mem[i*5+2];
            expected.overflow = case_mem[i*5+3][0];
            expected.illegal  = case_mem[i*5+4][0];
            expected.wr_en    = !expected.illegal && expected.rd != '0;
            @(negedge clk);
            instr_valid    = 1'b0;
            expected.valid = 1'b0;
            repeat (2 * b1 + b0) @(negedge clk);   // idle gap of 0 to 3
        end
        repeat (3) @(negedge clk);   // last retirement is due two cycles after issue
        final_check = 1'b1;
        @(negedge clk);
        $display("errors: %0d mismatched, %0d unexpected, %0d missing",
                 mismatch_count, extra_count, pending);
        if (mismatch_count == 0 && extra_count == 0 && pending == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/rv_exec_checker.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_checker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              retire_valid,
    input  logic [rv_exec_pkg::reg_idx_w-1:0] retire_rd,
    input  logic [rv_exec_pkg::xlen-1:0]      retire_value,
    input  logic                              retire_overflow,
    input  logic                              retire_illegal,
    input  rv_exec_pkg::retire_t              expected,   // pushed when valid
    input  logic                              final_check,
    output int                                mismatch_count,
    output int                                extra_count,
    output int                                pending
);
    import rv_exec_pkg::*;

    retire_t exp_queue[$];

    always @(posedge clk) begin
        retire_t head;
        if (reset) begin
            exp_queue.delete();
            mismatch_count = 0;
            extra_count    = 0;
            pending        = 0;
        end else begin
            if (retire_valid && exp_queue.size() == 0) begin
                $display("unexpected retirement at %0t: rd x%0d value %h with nothing issued",
                         $time, retire_rd, retire_value);
                extra_count++;
            end else if (retire_valid) begin
                head = exp_queue.pop_front();
                pending--;
                // value of an illegal instruction is not architectural
                if (retire_rd != head.rd || retire_overflow != head.overflow ||
                    retire_illegal != head.illegal ||
                    (!head.illegal && retire_value != head.value)) begin
                    $display("Fail %0t: got/expected rd x%0d/x%0d value %h/%h ovf %b/%b ill %b/%b",
                             $time, retire_rd, head.rd, retire_value, head.value,
                             retire_overflow, head.overflow, retire_illegal, head.illegal);
                    mismatch_count++;
                end
            end
            if (expected.valid) begin
                exp_queue.push_back(expected);
                pending++;
            end
        end
    end

    // whatever is left was issued but never retired
    always @(posedge final_check) begin
        foreach (exp_queue[i]) begin
            $display("missing retirement: rd x%0d value %h was issued but never retired",
                     exp_queue[i].rd, exp_queue[i].value);
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_top #(
    parameter int reg_count = 32
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              instr_valid,
    input  logic [rv_exec_pkg::ilen-1:0]      instr,
    output logic                              retire_valid,
    output logic [rv_exec_pkg::reg_idx_w-1:0] retire_rd,
    output logic [rv_exec_pkg::xlen-1:0]      retire_value,
    output logic                              retire_overflow,
    output logic                              retire_illegal
);
    import rv_exec_pkg::*;

    exe_ctl_t             exe;
    retire_t              retire;
    logic [xlen-1:0]      alu_value;
    logic                 alu_overflow;
    logic [reg_idx_w-1:0] rs1_addr;
    logic [reg_idx_w-1:0] rs2_addr;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;

    rv_decode #(
        .reg_count (reg_count)
    ) i_rv_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_value   (alu_value),
        .retire      (retire),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .exe         (exe)
    );

    rv_alu i_rv_alu (
        .op        (exe.op),
        .operand_a (exe.operand_a),
        .operand_b (exe.operand_b),
        .value     (alu_value),
        .overflow  (alu_overflow)
    );

    rv_result i_rv_result (
        .clk          (clk),
        .reset        (reset),
        .exe          (exe),
        .alu_value    (alu_value),
        .alu_overflow (alu_overflow),
        .retire       (retire)
    );

    rv_regfile #(
        .reg_count (reg_count)
    ) i_rv_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (retire),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign retire_valid    = retire.valid;
    assign retire_rd       = retire.rd;
    assign retire_value    = retire.value;
    assign retire_overflow = retire.overflow;
    assign retire_illegal  = retire.illegal;

endmodule

`default_nettype wire

// File: hw/rv_result.sv
`timescale 1ns/10ps
`default_nettype none

module rv_result (
    input  logic                         clk,
    input  logic                         reset,
    input  rv_exec_pkg::exe_ctl_t        exe,
    input  logic [rv_exec_pkg::xlen-1:0] alu_value,
    input  logic                         alu_overflow,
    output rv_exec_pkg::retire_t         retire
);
    import rv_exec_pkg::*;

    retire_t retire_next;

    always_comb begin
        retire_next.valid    = exe.valid;
        retire_next.rd       = exe.rd;
        retire_next.value    = alu_value;
        retire_next.wr_en    = exe.valid && exe.wr_en;
        retire_next.overflow = exe.valid && exe.ovf_en && alu_overflow;   // add, sub, addi only
        retire_next.illegal  = exe.valid && exe.illegal;
    end

    // feeds the outputs, the regfile write and the late bypass
    always_ff @(posedge clk) begin
        retire <= retire_next;
        if (reset) begin
            retire.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode #(
    parameter int reg_count = 32
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              instr_valid,
    input  logic [rv_exec_pkg::ilen-1:0]      instr,
    input  logic [rv_exec_pkg::xlen-1:0]      rs1_data,
    input  logic [rv_exec_pkg::xlen-1:0]      rs2_data,
    input  logic [rv_exec_pkg::xlen-1:0]      alu_value,
    input  rv_exec_pkg::retire_t              retire,
    output logic [rv_exec_pkg::reg_idx_w-1:0] rs1_addr,
    output logic [rv_exec_pkg::reg_idx_w-1:0] rs2_addr,
    output rv_exec_pkg::exe_ctl_t             exe
);
    import rv_exec_pkg::*;

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [reg_idx_w-1:0] rd;
    logic [xlen-1:0]      imm_i;
    logic [xlen-1:0]      imm_u;
    logic [xlen-1:0]      rs1_value;
    logic [xlen-1:0]      rs2_value;
    logic                 alt;
    logic                 legal;
    logic                 use_rs2;
    alu_op_t              op;
    exe_ctl_t             exe_next;

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign funct7   = instr[31:25];
    assign alt      = (funct7 == f7_alt);
    assign imm_i    = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign imm_u    = {instr[31:12], 12'b0};

    function automatic alu_op_t op_of(input logic [2:0] f3, input logic use_alt);
        case (f3)
            f3_add_sub: return use_alt ? alu_sub : alu_add;
            f3_sll:     return alu_sll;
            f3_slt:     return alu_slt;
            f3_sltu:    return alu_sltu;
            f3_xor:     return alu_xor;
            f3_srl_sra: return use_alt ? alu_sra : alu_srl;
            f3_or:      return alu_or;
            default:    return alu_and;
        endcase
    endfunction

    // youngest producer wins, x0 is always zero
    function automatic logic [xlen-1:0] bypass(input logic [reg_idx_w-1:0] src,
                                               input logic [xlen-1:0]      rf_data);
        if (src == '0) begin
            return '0;
        end else if (exe.valid && exe.wr_en && exe.rd == src) begin
            return alu_value;
        end else if (retire.valid && retire.wr_en && retire.rd == src) begin
            return retire.value;
        end
        return rf_data;
    endfunction

    always_comb begin
        op      = alu_add;
        legal   = 1'b1;
        use_rs2 = 1'b0;
        case (opcode)
            op_reg: begin
                use_rs2 = 1'b1;
                op      = op_of(funct3, alt);
                if (funct7 != f7_base &&
                    !(alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra))) begin
                    legal = 1'b0;
                end
            end
            op_imm: begin
                op = op_of(funct3, alt && funct3 == f3_srl_sra);   // addi never subtracts
                if (funct3 == f3_sll && funct7 != f7_base) begin
                    legal = 1'b0;
                end
                if (funct3 == f3_srl_sra && funct7 != f7_base && !alt) begin
                    legal = 1'b0;
                end
            end
            op_lui: begin
                op = alu_pass_b;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        if (int'(rd) >= reg_count) begin
            legal = 1'b0;   // rv32e range
        end
        if (opcode != op_lui && int'(rs1_addr) >= reg_count) begin
            legal = 1'b0;
        end
        if (use_rs2 && int'(rs2_addr) >= reg_count) begin
            legal = 1'b0;
        end
    end

    always_comb begin
        rs1_value = bypass(rs1_addr, rs1_data);
        rs2_value = bypass(rs2_addr, rs2_data);
    end

    always_comb begin
        exe_next.valid     = instr_valid;
        exe_next.op        = op;
        exe_next.operand_a = rs1_value;
        case (opcode)
            op_imm:  exe_next.operand_b = imm_i;
            op_lui:  exe_next.operand_b = imm_u;
            default: exe_next.operand_b = rs2_value;
        endcase
        exe_next.rd      = rd;
        exe_next.wr_en   = legal && (rd != '0);
        exe_next.ovf_en  = legal && (op == alu_add || op == alu_sub);
        exe_next.illegal = !legal;
    end

    always_ff @(posedge clk) begin
        exe <= exe_next;
        if (reset) begin
            exe.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
    input  rv_exec_pkg::alu_op_t         op,
    input  logic [rv_exec_pkg::xlen-1:0] operand_a,
    input  logic [rv_exec_pkg::xlen-1:0] operand_b,
    output logic [rv_exec_pkg::xlen-1:0] value,
    output logic                         overflow
);
    import rv_exec_pkg::*;

    logic                     subtract;
    logic [xlen-1:0]          sum;
    logic                     add_overflow;
    logic [$clog2(xlen)-1:0]  shamt;

    assign subtract = (op == alu_sub) || (op == alu_slt);   // slt reuses the subtractor
    assign shamt    = operand_b[$clog2(xlen)-1:0];

    always_comb begin
        value    = '0;
        overflow = 1'b0;
        case (op)
            alu_add, alu_sub: begin
                value    = sum;
                overflow = add_overflow;
            end
            alu_slt: begin
                if (operand_a[xlen-1] != operand_b[xlen-1]) begin
                    value = {{(xlen-1){1'b0}}, operand_a[xlen-1]};   // negative side is less
                end else begin
                    value = {{(xlen-1){1'b0}}, sum[xlen-1]};
                end
            end
            alu_sltu: begin
                value = {{(xlen-1){1'b0}}, (operand_a < operand_b)};
            end
            alu_xor: begin
                value = operand_a ^ operand_b;
            end
            alu_or: begin
                value = operand_a | operand_b;
            end
            alu_and: begin
                value = operand_a & operand_b;
            end
            alu_sll: begin
                value = operand_a << shamt;
            end
            alu_srl: begin
                value = operand_a >> shamt;
            end
            alu_sra: begin
                value = $unsigned($signed(operand_a) >>> shamt);
            end
            alu_pass_b: begin
                value = operand_b;
            end
            default: begin
                value    = '0;
                overflow = 1'b0;
            end
        endcase
    end

    rv_adder i_rv_adder (
        .subtract (subtract),
        .add_1    (operand_a),
        .add_2    (operand_b),
        .sum      (sum),
        .overflow (add_overflow)
    );

endmodule

`default_nettype wire

// File: hw/rv_adder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_adder (
    input  logic                         subtract,
    input  logic [rv_exec_pkg::xlen-1:0] add_1,
    input  logic [rv_exec_pkg::xlen-1:0] add_2,
    output logic [rv_exec_pkg::xlen-1:0] sum,
    output logic                         overflow
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] operand_b;

    assign operand_b = subtract ? ~add_2 : add_2;   // two's complement via carry in
    assign sum       = add_1 + operand_b + {{(xlen-1){1'b0}}, subtract};

    // same effective signs in, other sign out
    assign overflow = (add_1[xlen-1] == operand_b[xlen-1]) && (sum[xlen-1] != add_1[xlen-1]);

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile #(
    parameter int reg_count = 32
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [rv_exec_pkg::reg_idx_w-1:0] rs1_addr,
    input  logic [rv_exec_pkg::reg_idx_w-1:0] rs2_addr,
    input  rv_exec_pkg::retire_t              wb,
    output logic [rv_exec_pkg::xlen-1:0]      rs1_data,
    output logic [rv_exec_pkg::xlen-1:0]      rs2_data
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.wr_en && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // x0 and out of range indices read as zero
    assign rs1_data = (rs1_addr == '0 || int'(rs1_addr) >= reg_count) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0 || int'(rs2_addr) >= reg_count) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: hw/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    localparam int xlen      = 32;
    localparam int ilen      = 32;
    localparam int reg_idx_w = 5;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10      // lui
    } alu_op_t;

    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_lui = 7'b0110111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;   // sub, sra

    typedef struct packed {
        logic                 valid;
        alu_op_t              op;
        logic [xlen-1:0]      operand_a;
        logic [xlen-1:0]      operand_b;   // imm already muxed in
        logic [reg_idx_w-1:0] rd;
        logic                 wr_en;
        logic                 ovf_en;
        logic                 illegal;
    } exe_ctl_t;

    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      value;
        logic                 wr_en;
        logic                 overflow;
        logic                 illegal;
    } retire_t;

endpackage

`default_nettype wire
